//--- avr_core.f
+incdir+verif
hw/isa_pkg.sv
hw/core_pkg.sv
hw/avr_decoder.sv
hw/avr_regfile.sv
hw/avr_alu.sv
hw/avr_sequencer.sv
hw/avr_core.sv
verif/avr_core_tb.sv

//--- Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= avr_core_tb
FLIST     ?= avr_core.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

//--- verif/tb_program.svh
// test program of the core testbench
// instruction encoders, a register and flag model of the core,
// and the task that builds the ROM image with its expected bus events

`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic insn_t enc_rr(logic [5:0] op, int d, int r);
  return {op, r[4], d[4:0], r[3:0]};
endfunction

function automatic insn_t enc_imm(logic [3:0] op, int d, word_t kv);
  return {op, kv[7:4], d[3:0], kv[3:0]};
endfunction

function automatic insn_t enc_out(int a, int r);
  return {5'b10111, a[5:4], r[4:0], a[3:0]};
endfunction

// clr selects BRBC and ofs counts words from the next address
function automatic insn_t enc_br(bit clr, int ofs, int s);
  return {5'b11110, clr, ofs[6:0], s[2:0]};
endfunction

function automatic insn_t enc_rjmp(int ofs);
  return {4'b1100, ofs[11:0]};
endfunction

// mode 1 is X+ and mode 2 is -X
function automatic insn_t enc_ldst(bit st, int r, int mode);
  return {6'b100100, st, r[4:0], 2'b11, mode[1:0]};
endfunction

////////////////////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////////////////////

task automatic model_add(int d, int r, bit carry);
  int sum;
  int ssum;
  int cin;
  cin  = (carry && fc) ? 1 : 0;
  sum  = int'(m_reg[d]) + int'(m_reg[r]) + cin;
  ssum = int'($signed(m_reg[d])) + int'($signed(m_reg[r])) + cin;
  fc   = (sum > 255);
  fv   = (ssum > 127) || (ssum < -128);
  m_reg[d] = word_t'(sum);
  fn   = m_reg[d][7];
  fz   = (m_reg[d] == 8'h00);
endtask

// carry selects SBC/CPC behavior and wb is off for compares
task automatic model_sub(int d, word_t bv, bit carry, bit wb);
  int diff;
  int sdiff;
  int cin;
  word_t res;
  cin   = (carry && fc) ? 1 : 0;
  diff  = int'(m_reg[d]) - int'(bv) - cin;
  sdiff = int'($signed(m_reg[d])) - int'($signed(bv)) - cin;
  res   = word_t'(diff);
  fc    = (diff < 0);
  fv    = (sdiff > 127) || (sdiff < -128);
  fn    = res[7];
  fz    = (res == 8'h00) && (!carry || fz);
  if (wb) m_reg[d] = res;
endtask

task automatic model_logic(int d, word_t res);
  m_reg[d] = res;
  fv = 1'b0;
  fn = res[7];
  fz = (res == 8'h00);
endtask

function automatic bit branch_taken(bit clr, int s);
  bit flag;
  case (s)
    0:       flag = fc;
    1:       flag = fz;
    2:       flag = fn;
    default: flag = fv;
  endcase
  return flag ^ clr;
endfunction

task automatic emit(insn_t w);
  rom[pc_emit] = w;
  pc_emit++;
endtask

task automatic push_io(int a, word_t dv, string name);
  exp_io_a[exp_io_n]    = IO_ADDR_W'(a);
  exp_io_d[exp_io_n]    = dv;
  exp_io_name[exp_io_n] = name;
  exp_io_n++;
endtask

task automatic out_expect(int a, int r, string name);
  emit(enc_out(a, r));
  push_io(a, m_reg[r], name);
endtask

// branch over one OUT marker that shows only on fall-through
task automatic branch_over(bit clr, int s, int a, string name);
  emit(enc_br(clr, 1, s));
  emit(enc_out(a, 22));
  if (!branch_taken(clr, s)) push_io(a, m_reg[22], name);
endtask

task automatic load_imm(int d, word_t kv);
  emit(enc_imm(4'b1110, d, kv));
  m_reg[d] = kv;
endtask

////////////////////////////////////////////////////////////////////////////
// program
////////////////////////////////////////////////////////////////////////////

task automatic build_program();
  word_t kv;
  int x;
  int n;
  for (int i = 16; i < 24; i++) load_imm(i, lcg_byte());
  // register ALU ops with each result sent out on the bus
  emit(enc_rr(6'b000011, 16, 17));
  model_add(16, 17, 1'b0);
  out_expect(1, 16, "alu_add");
  emit(enc_rr(6'b000111, 18, 19));
  model_add(18, 19, 1'b1);
  out_expect(2, 18, "alu_adc");
  emit(enc_rr(6'b000110, 20, 16));
  model_sub(20, m_reg[16], 1'b0, 1'b1);
  out_expect(3, 20, "alu_sub");
  emit(enc_rr(6'b000010, 21, 17));
  model_sub(21, m_reg[17], 1'b1, 1'b1);
  out_expect(4, 21, "alu_sbc");
  emit(enc_rr(6'b001000, 17, 18));
  model_logic(17, m_reg[17] & m_reg[18]);
  out_expect(5, 17, "alu_and");
  emit(enc_rr(6'b001010, 19, 20));
  model_logic(19, m_reg[19] | m_reg[20]);
  out_expect(6, 19, "alu_or");
  emit(enc_rr(6'b001001, 16, 21));
  model_logic(16, m_reg[16] ^ m_reg[21]);
  out_expect(7, 16, "alu_eor");
  kv = lcg_byte();
  emit(enc_imm(4'b0111, 18, kv));
  model_logic(18, m_reg[18] & kv);
  out_expect(8, 18, "alu_andi");
  kv = lcg_byte();
  emit(enc_imm(4'b0110, 20, kv));
  model_logic(20, m_reg[20] | kv);
  out_expect(9, 20, "alu_ori");
  emit(enc_rr(6'b001011, 2, 19));
  m_reg[2] = m_reg[19];
  out_expect(10, 2, "alu_mov");
  // flag branches after compares both ways round
  emit(enc_rr(6'b000101, 22, 23));
  model_sub(22, m_reg[23], 1'b0, 1'b0);
  branch_over(1'b0, 0, 16, "flag_brbs_c");
  branch_over(1'b1, 1, 17, "flag_brbc_z");
  branch_over(1'b0, 2, 18, "flag_brbs_n");
  branch_over(1'b1, 3, 19, "flag_brbc_v");
  emit(enc_rr(6'b000101, 23, 22));
  model_sub(23, m_reg[22], 1'b0, 1'b0);
  branch_over(1'b1, 0, 20, "flag_brbc_c");
  branch_over(1'b0, 2, 21, "flag_brbs_n2");
  branch_over(1'b0, 3, 22, "flag_brbs_v");
  // 16-bit compare with both bytes equal
  emit(enc_rr(6'b000101, 16, 16));
  model_sub(16, m_reg[16], 1'b0, 1'b0);
  emit(enc_rr(6'b000001, 17, 17));
  model_sub(17, m_reg[17], 1'b1, 1'b0);
  branch_over(1'b0, 1, 23, "flag_cpc_z_eq")
;
  // low byte one above, so CP clears C and Z and CPC gives zero
  kv = lcg_byte() | 8'h01;
  load_imm(24, kv);
  load_imm(25, kv - 8'h01);
  emit(enc_rr(6'b000101, 24, 25));
  model_sub(24, m_reg[25], 1'b0, 1'b0);
  emit(enc_rr(6'b000001, 17, 17));
  model_sub(17, m_reg[17], 1'b1, 1'b0);
  branch_over(1'b0, 1, 24, "flag_cpc_z_ne");
  // ST X+ then LD -X reads the bytes back in reverse
  load_imm(26, 8'h40);
  load_imm(27, 8'h00);
  x = 'h40;
  for (int r = 16; r < 20; r++) begin
    emit(enc_ldst(1'b1, r, 1));
    exp_dm_a[exp_dm_n] = x[12:0];
    exp_dm_d[exp_dm_n] = m_reg[r];
    exp_dm_n++;
    m_mem[x] = m_reg[r];
    x++;
  end
  for (int d = 22; d < 26; d++) begin
    emit(enc_ldst(1'b0, d, 2));
    x--;
    m_reg[d] = m_mem[x];
  end
  for (int d = 22; d < 26; d++) out_expect(32 + d - 22, d, "mem_ld_reverse");
  // countdown loop
  n = 1 + int'(lcg_byte() % 5);
  load_imm(24, word_t'(n));
  emit(enc_out(48, 24));
  emit(enc_imm(4'b0101, 24, 8'h01));
  emit(enc_br(1'b1, -3, 1));
  for (int i = 0; i < n; i++) begin
    push_io(48, m_reg[24], "jump_loop");
    model_sub(24, 8'h01, 1'b0, 1'b1);
  end
  emit(enc_rjmp(1));
  emit(enc_out(63, 24));
  out_expect(62, 24, "jump_end");
  emit(enc_rjmp(-1));
endtask

`endif

//--- verif/avr_core_tb.sv
// testbench of the 8-bit core
// clock, reset, program ROM and data RAM models, watchdog
// and concurrent assertions on the data and peripheral buses

`timescale 1ns/1ps

module avr_core_tb
  import core_pkg::*, isa_pkg::*;
;

  localparam int PMEM_AW = 11;
  localparam int DMEM_AW = 13;

  logic                 clk;
  logic                 rst;
  logic                 pmem_ce;
  logic [PMEM_AW-1:0]   pmem_a;
  insn_t                pmem_d;
  logic                 dmem_we;
  logic [DMEM_AW-1:0]   dmem_a;
  word_t                dmem_do;
  word_t                dmem_di;
  logic                 io_we;
  logic [IO_ADDR_W-1:0] io_a;
  word_t                io_do;

  insn_t                rom [2**PMEM_AW];
  word_t                ram [2**DMEM_AW];
  logic [31:0]          lcg_state = 32'hd9a5_89c6;
  int                   pc_emit;
  int                   cycle_limit;

  // model state and expected events
  word_t                m_reg [32];
  word_t                m_mem [256];
  logic                 fc, fz, fn, fv;
  logic [IO_ADDR_W-1:0] exp_io_a [64];
  word_t                exp_io_d [64];
  string                exp_io_name [64];
  int                   exp_io_n;
  logic [DMEM_AW-1:0]   exp_dm_a [16];
  word_t                exp_dm_d [16];
  int                   exp_dm_n;
  int                   io_cnt;
  int                   dm_cnt;
  logic                 fetched;

  function automatic word_t lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  `include "tb_program.svh"

  avr_core #(.PMEM_AW (PMEM_AW), .DMEM_AW (DMEM_AW)) DUT (
    .clk (clk), .rst (rst),
    .pmem_ce (pmem_ce), .pmem_a (pmem_a), .pmem_d (pmem_d),
    .dmem_we (dmem_we), .dmem_a (dmem_a), .dmem_do (dmem_do), .dmem_di (dmem_di),
    .io_we (io_we), .io_a (io_a), .io_do (io_do)
  );

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic fail_run(string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  task automatic fail_value(string name, int expv, int actv);
    $display("ERROR %s: expected %0h, actual %0h", name, expv, actv);
    stop_with_failure();
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory models and event counters
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (pmem_ce) pmem_d <= rom[pmem_a];
    if (dmem_we) ram[dmem_a] <= dmem_do;
    dmem_di <= ram[dmem_a];
  end

  always @(posedge clk) begin
    if (rst) begin
      io_cnt  <= 0;
      dm_cnt  <= 0;
      fetched <= 1'b0;
    end else begin
      if (io_we) io_cnt <= io_cnt + 1;
      if (dmem_we) dm_cnt <= dm_cnt + 1;
      if (pmem_ce) fetched <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) rst |-> !dmem_we && !io_we)
    else fail_run("dmem_we or io_we was high during reset");
  assert property (@(posedge clk) $fell(rst) |-> !dmem_we && !io_we)
    else fail_run("dmem_we or io_we was high on the first cycle after reset");
  assert property (@(posedge clk) disable iff (rst) pmem_ce && !fetched |-> pmem_a == '0)
    else fail_value("reset_fetch", 0, $sampled(pmem_a));

  assert property (@(posedge clk) disable iff (rst) io_we |-> io_cnt < exp_io_n)
    else fail_run("peripheral write beyond the expected sequence");
  assert property (@(posedge clk) disable iff (rst)
    io_we && (io_cnt < exp_io_n) |-> io_do == exp_io_d[io_cnt])
    else fail_value(exp_io_name[$sampled(io_cnt)], exp_io_d[$sampled(io_cnt)],
                    $sampled(io_do));
  assert property (@(posedge clk) disable iff (rst)
    io_we && (io_cnt < exp_io_n) |-> io_a == exp_io_a[io_cnt])
    else fail_value({exp_io_name[$sampled(io_cnt)], " io_a"},
                    exp_io_a[$sampled(io_cnt)], $sampled(io_a));

  assert property (@(posedge clk) disable iff (rst) dmem_we |-> dm_cnt < exp_dm_n)
    else fail_run("data memory write beyond the expected sequence");
  assert property (@(posedge clk) disable iff (rst)
    dmem_we && (dm_cnt < exp_dm_n) |-> dmem_a == exp_dm_a[dm_cnt])
    else fail_value("mem_st_addr", exp_dm_a[$sampled(dm_cnt)], $sampled(dmem_a));
  assert property (@(posedge clk) disable iff (rst)
    dmem_we && (dm_cnt < exp_dm_n) |-> dmem_do == exp_dm_d[dm_cnt])
    else fail_value("mem_st_data", exp_dm_d[$sampled(dm_cnt)], $sampled(dmem_do));

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst         = 1'b1;
    pmem_d      = '0;
    dmem_di     = '0;
    pc_emit     = 0;
    exp_io_n    = 0;
    exp_dm_n    = 0;
    cycle_limit = 0;
    {fc, fz, fn, fv} = 4'b0000;
    for (int i = 0; i < 2**PMEM_AW; i++) rom[i] = '0;
    for (int i = 0; i < 2**DMEM_AW; i++) ram[i] = word_t'(i * 7) ^ word_t'(i >> 8);
    for (int i = 0; i < 32; i++) m_reg[i] = '0;
    build_program();
    cycle_limit = pc_emit * 4 + 100;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait (io_cnt == exp_io_n);
    // extra bus events in this window trip the assertions
    repeat (20) @(posedge clk);
    if (dm_cnt != exp_dm_n) begin
      fail_value("mem_st_count", exp_dm_n, dm_cnt);
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

  initial begin
    wait (cycle_limit > 0);
    repeat (cycle_limit) @(posedge clk);
    fail_run("timeout: the program did not produce all expected bus events");
  end

endmodule

//--- hw/avr_core.sv
// top level of the 8-bit core
// decoder, register file, ALU and sequencer with the program,
// data and peripheral bus ports

`timescale 1ns/1ps

module avr_core
  import core_pkg::*, isa_pkg::*;
#(
  parameter int PMEM_AW = 11,
  parameter int DMEM_AW = 13
)(
  input  logic                 clk,
  input  logic                 rst,
  output logic                 pmem_ce,
  output logic [PMEM_AW-1:0]   pmem_a,
  input  insn_t                pmem_d,
  output logic                 dmem_we,
  output logic [DMEM_AW-1:0]   dmem_a,
  output word_t                dmem_do,
  input  word_t                dmem_di,
  output logic                 io_we,
  output logic [IO_ADDR_W-1:0] io_a,
  output word_t                io_do
);

  ctrl_t      ctrl;
  reg_addr_t  rd;
  reg_addr_t  rr;
  word_t      k;
  logic [2:0] b;
  word_t      rd_val;
  word_t      rr_val;
  word_t      alu_b;
  word_t      result;
  ptr_t       x_val;
  ptr_t       dmem_ptr;
  sreg_t      sreg;
  logic       exec_en;
  logic       load_done;
  logic       ptr_step;
  logic       reg_we;

  avr_decoder u_decoder (
    .insn (pmem_d), .ctrl (ctrl), .rd (rd), .rr (rr), .k (k), .b (b)
  );

  // LD writes in its second cycle, everything else while executing
  assign reg_we = ctrl.writeback
               && ((exec_en && (ctrl.insn_class != CLS_LD)) || load_done);

  avr_regfile #(.DMEM_AW (DMEM_AW)) u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rd       (rd),
    .rr       (rr),
    .we       (reg_we),
    .wdata    (result),
    .ptr_mode (ctrl.ptr_mode),
    .ptr_step (ptr_step),
    .rd_val   (rd_val),
    .rr_val   (rr_val),
    .x_val    (x_val)
  );

  assign alu_b = ctrl.use_imm ? k : rr_val;

  avr_alu u_alu (
    .clk (clk), .rst (rst), .ctrl (ctrl), .exec_en (exec_en),
    .a (rd_val), .b_op (alu_b), .load_data (dmem_di),
    .result (result), .sreg (sreg)
  );

  avr_sequencer #(.PMEM_AW (PMEM_AW)) u_sequencer (
    .clk (clk), .rst (rst), .ctrl (ctrl), .insn (pmem_d), .sreg (sreg),
    .pmem_ce (pmem_ce), .pmem_a (pmem_a), .exec_en (exec_en),
    .load_done (load_done), .dmem_we (dmem_we), .io_we (io_we),
    .ptr_step (ptr_step)
  );

  // -X addresses the byte below the pointer
  assign dmem_ptr = (ctrl.ptr_mode == PTR_X_DEC) ? x_val - PTR_W'(1) : x_val;
  assign dmem_a   = dmem_ptr[DMEM_AW-1:0];
  assign dmem_do  = rd_val;
  assign io_do    = rd_val;
  assign io_a     = {pmem_d[IO_A_HI_LSB +: 2], pmem_d[IO_A_LO_LSB +: 4]};

  // a taken branch is followed by a dead cycle
  assert property (@(posedge clk) disable iff (rst)
    exec_en && (ctrl.insn_class == CLS_BRANCH) && (sreg[b] != pmem_d[BR_CLR_BIT])
    |=> !exec_en);

endmodule

//--- hw/avr_sequencer.sv
// instruction sequencer
// program counter, fetch enable, multi-cycle FSM and bus strobes

`timescale 1ns/1ps

module avr_sequencer
  import core_pkg::*, isa_pkg::*;
#(
  parameter int PMEM_AW = 11
)(
  input  logic               clk,
  input  logic               rst,
  input  ctrl_t              ctrl,
  input  insn_t              insn,
  input  sreg_t              sreg,
  output logic               pmem_ce,
  output logic [PMEM_AW-1:0] pmem_a,
  output logic               exec_en,
  output logic               load_done,
  output logic               dmem_we,
  output logic               io_we,
  output logic               ptr_step
);

  typedef enum logic [1:0] {RUN, STALL, LOAD_WB} state_e;

  state_e             state;
  state_e             state_next;
  logic [PMEM_AW-1:0] pc;
  logic [PMEM_AW-1:0] pc_inc;
  logic [PMEM_AW-1:0] pc_next;
  logic [PMEM_AW-1:0] jmp_ofs;
  logic [PMEM_AW-1:0] br_ofs;
  logic               br_taken;

  // pc is the address of the word now on pmem_d
  assign pc_inc   = pc + PMEM_AW'(1);
  assign pmem_a   = pc_inc;
  assign jmp_ofs  = PMEM_AW'($signed(insn[JMP_OFS_LSB +: JMP_OFS_W]));
  assign br_ofs   = PMEM_AW'($signed(insn[BR_OFS_LSB +: BR_OFS_W]));
  assign br_taken = sreg[insn[B_LSB +: 3]] ^ insn[BR_CLR_BIT];

  assign exec_en  = (state == RUN);
  assign dmem_we  = exec_en && ctrl.store;
  assign io_we    = exec_en && (ctrl.insn_class == CLS_OUT);
  assign ptr_step = exec_en && (ctrl.ptr_mode != PTR_X);

  //////////////////////////////////////////////////////////////////////////
  // next state and next pc
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = RUN;
    pc_next    = pc_inc;
    pmem_ce    = 1'b1;
    load_done  = 1'b0;
    case (state)
      RUN: begin
        case (ctrl.insn_class)
          // pc holds target - 1, the stall fetches the target
          CLS_RJMP: begin
            pc_next    = pc + jmp_ofs;
            state_next = STALL;
          end
          CLS_BRANCH: begin
            if (br_taken) begin
              pc_next    = pc + br_ofs;
              state_next = STALL;
            end
          end
          // hold the LD word for the writeback cycle
          CLS_LD: begin
            pmem_ce    = 1'b0;
            pc_next    = pc;
            state_next = LOAD_WB;
          end
          default: ;
        endcase
      end
      LOAD_WB: load_done = 1'b1;
      default: ;
    endcase
  end

  // the stall after reset fetches word 0
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= STALL;
      pc    <= '1;
    end else begin
      state <= state_next;
      pc    <= pc_next;
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(dmem_we && io_we));

endmodule

//--- hw/avr_alu.sv
// arithmetic and logic unit
// add and subtract with carry chain, logic ops, move and load select
// holds the status register

`timescale 1ns/1ps

module avr_alu
  import core_pkg::*, isa_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  ctrl_t ctrl,
  input  logic  exec_en,
  input  word_t a,
  input  word_t b_op,
  input  word_t load_data,
  output word_t result,
  output sreg_t sreg
);

  alu_res_t        res;
  logic [WORD_W:0] sum;
  logic            cin;
  logic            flag_n;
  logic            flag_z;

  assign cin = ctrl.carry_in_en & sreg.c;

  //////////////////////////////////////////////////////////////////////////
  // result
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    res = '0;
    sum = '0;
    case (ctrl.alu_op)
      ALU_ADD: begin
        sum       = {1'b0, a} + {1'b0, b_op} + {{WORD_W{1'b0}}, cin};
        res.value = sum[WORD_W-1:0];
        res.c     = sum[WORD_W];
        res.h     = (a[3] & b_op[3]) | (b_op[3] & ~sum[3]) | (~sum[3] & a[3]);
        res.v     = (a[7] & b_op[7] & ~sum[7]) | (~a[7] & ~b_op[7] & sum[7]);
        res.arith = 1'b1;
      end
      ALU_SUB: begin
        // bit 8 of the 9-bit difference is the borrow
        sum       = {1'b0, a} - {1'b0, b_op} - {{WORD_W{1'b0}}, cin};
        res.value = sum[WORD_W-1:0];
        res.c     = sum[WORD_W];
        res.h     = (~a[3] & b_op[3]) | (b_op[3] & sum[3]) | (sum[3] & ~a[3]);
        res.v     = (a[7] & ~b_op[7] & ~sum[7]) | (~a[7] & b_op[7] & sum[7]);
        res.arith = 1'b1;
      end
      // logic ops leave v at zero
      ALU_AND:          res.value = a & b_op;
      ALU_OR:           res.value = a | b_op;
      ALU_EOR:          res.value = a ^ b_op;
      ALU_MOV, ALU_LDI: res.value = b_op;
      ALU_LOAD:         res.value = load_data;
      default: ;
    endcase
  end

  assign result = res.value;
  assign flag_n = res.value[WORD_W-1];
  // CPC/SBC/SBCI: z only survives while every byte compares zero
  assign flag_z = (res.value == '0) && (!ctrl.keep_z || sreg.z);

  //////////////////////////////////////////////////////////////////////////
  // status register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      sreg <= '0;
    end else if (exec_en && ctrl.update_flags) begin
      if (res.arith) begin
        sreg.c <= res.c;
        sreg.h <= res.h;
      end
      sreg.v <= res.v;
      sreg.n <= flag_n;
      sreg.s <= flag_n ^ res.v;
      sreg.z <= flag_z;
    end
  end

endmodule

//--- hw/avr_regfile.sv
// general purpose register file, 32 x 8 bit
// two combinational read ports, one write port, X pointer step

`timescale 1ns/1ps

module avr_regfile
  import core_pkg::*, isa_pkg::*;
#(
  parameter int DMEM_AW = 13
)(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rd,
  input  reg_addr_t rr,
  input  logic      we,
  input  word_t     wdata,
  input  ptr_mode_e ptr_mode,
  input  logic      ptr_step,
  output word_t     rd_val,
  output word_t     rr_val,
  output ptr_t      x_val
);

  localparam reg_addr_t X_LO = 5'd26;
  localparam reg_addr_t X_HI = 5'd27;

  word_t              regs [32];
  logic [DMEM_AW-1:0] x_low;
  ptr_t               x_next;

  assign rd_val = regs[rd];
  assign rr_val = regs[rr];
  assign x_val  = {regs[X_HI], regs[X_LO]};

  // pointer wraps inside the data space
  always_comb begin
    x_low = x_val[DMEM_AW-1:0];
    case (ptr_mode)
      PTR_X_INC: x_low = x_low + DMEM_AW'(1);
      PTR_X_DEC: x_low = x_low - DMEM_AW'(1);
      default: ;
    endcase
    x_next = {x_val[PTR_W-1:DMEM_AW], x_low};
  end

  always_ff @(posedge clk) begin
    if (we) begin
      regs[rd] <= wdata;
    end else if (ptr_step) begin
      {regs[X_HI], regs[X_LO]} <= x_next;
    end
  end

  // load writeback and pointer step fall in different cycles
  assert property (@(posedge clk) disable iff (rst) !(we && ptr_step));

endmodule

//--- hw/avr_decoder.sv
// instruction decoder
// classifies the fetched word and builds the control word,
// register addresses, immediate and status bit index

`timescale 1ns/1ps

module avr_decoder
  import core_pkg::*, isa_pkg::*;
(
  input  insn_t      insn,
  output ctrl_t      ctrl,
  output reg_addr_t  rd,
  output reg_addr_t  rr,
  output word_t      k,
  output logic [2:0] b
);

  logic m_nop;
  logic m_alu;
  logic m_rjmp;
  logic m_branch;
  logic m_ldst;
  logic m_ld;
  logic m_st;
  logic m_out;

  //////////////////////////////////////////////////////////////////////////
  // opcode patterns
  //////////////////////////////////////////////////////////////////////////

  assign m_nop    = (insn == '0);
  // 0000_00 and 0001_00 stay out, NOP and CPSE
  assign m_alu    = ((insn[15:13] == 3'b000) && (insn[11:10] != 2'b00))
                 || (insn[15:13] == 3'b001) || (insn[15:14] == 2'b01)
                 || (insn[15:12] == 4'b1110);
  assign m_rjmp   = (insn[15:12] == 4'b1100);
  assign m_branch = (insn[15:11] == 5'b11110);
  // X, X+ and -X only
  assign m_ldst   = (insn[15:10] == 6'b100100) && (insn[3:2] == 2'b11)
                 && (insn[1:0] != 2'b11);
  assign m_ld     = m_ldst && !insn[ST_BIT];
  assign m_st     = m_ldst && insn[ST_BIT];
  assign m_out    = (insn[15:11] == 5'b10111);

  always_comb begin
    assert ($onehot0({m_nop, m_alu, m_rjmp, m_branch, m_ld, m_st, m_out}))
      else $error("decoder: overlapping instruction classes");
  end

  //////////////////////////////////////////////////////////////////////////
  // control word
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl            = '0;
    ctrl.insn_class = CLS_NOP;
    ctrl.alu_op     = ALU_ADD;
    ctrl.ptr_mode   = PTR_X;
    if (m_alu) begin
      ctrl.insn_class   = CLS_ALU;
      ctrl.writeback    = 1'b1;
      ctrl.update_flags = 1'b1;
      casez (insn[15:10])
        6'b000?11: ctrl.carry_in_en = insn[CARRY_SEL_BIT];
        // SUB/SBC write back, CP/CPC do not
        6'b000?10, 6'b000?01: begin
          ctrl.alu_op      = ALU_SUB;
          ctrl.carry_in_en = !insn[CARRY_SEL_BIT];
          ctrl.keep_z      = !insn[CARRY_SEL_BIT];
          ctrl.writeback   = insn[11];
        end
        6'b001000: ctrl.alu_op = ALU_AND;
        6'b001001: ctrl.alu_op = ALU_EOR;
        6'b001010: ctrl.alu_op = ALU_OR;
        6'b001011: begin
          ctrl.alu_op       = ALU_MOV;
          ctrl.update_flags = 1'b0;
        end
        // CPI, SBCI, SUBI
        6'b0011??, 6'b010???: begin
          ctrl.alu_op      = ALU_SUB;
          ctrl.use_imm     = 1'b1;
          ctrl.carry_in_en = !insn[CARRY_SEL_BIT];
          ctrl.keep_z      = !insn[CARRY_SEL_BIT];
          ctrl.writeback   = insn[14];
        end
        6'b0110??: begin
          ctrl.alu_op  = ALU_OR;
          ctrl.use_imm = 1'b1;
        end
        6'b0111??: begin
          ctrl.alu_op  = ALU_AND;
          ctrl.use_imm = 1'b1;
        end
        6'b1110??: begin
          ctrl.alu_op       = ALU_LDI;
          ctrl.use_imm      = 1'b1;
          ctrl.update_flags = 1'b0;
        end
        default: ;
      endcase
    end else if (m_rjmp) begin
      ctrl.insn_class = CLS_RJMP;
    end else if (m_branch) begin
      ctrl.insn_class = CLS_BRANCH;
    end else if (m_ldst) begin
      ctrl.insn_class = m_st ? CLS_ST : CLS_LD;
      ctrl.store      = m_st;
      ctrl.writeback  = m_ld;
      ctrl.alu_op     = ALU_LOAD;
      case (insn[1:0])
        2'b01:   ctrl.ptr_mode = PTR_X_INC;
        2'b10:   ctrl.ptr_mode = PTR_X_DEC;
        default: ctrl.ptr_mode = PTR_X;
      endcase
    end else if (m_out) begin
      ctrl.insn_class = CLS_OUT;
    end
  end

  // immediate forms only reach r16..r31
  assign rd = {ctrl.use_imm | insn[RD_HI_BIT], insn[RD_LSB +: 4]};
  assign rr = {insn[RR_HI_BIT], insn[RR_LSB +: 4]};
  assign k  = {insn[K_HI_LSB +: 4], insn[K_LO_LSB +: 4]};
  assign b  = insn[B_LSB +: 3];

endmodule

//--- hw/core_pkg.sv
// datapath widths and shared types of the core
// status register layout, decoded control word and ALU result bundle

package core_pkg;
  import isa_pkg::*;

  localparam int WORD_W = 8;
  localparam int INSN_W = 16;
  localparam int REG_AW = 5;
  localparam int PTR_W  = 16;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [INSN_W-1:0] insn_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [PTR_W-1:0]  ptr_t;

  // c sits in bit 0, bit numbers match BRBS/BRBC
  typedef struct packed {
    logic i;
    logic t;
    logic h;
    logic s;
    logic v;
    logic n;
    logic z;
    logic c;
  } sreg_t;

  typedef struct packed {
    insn_class_e insn_class;
    alu_op_e     alu_op;
    logic        use_imm;
    logic        writeback;
    logic        update_flags;
    logic        keep_z;
    logic        carry_in_en;
    ptr_mode_e   ptr_mode;
    logic        store;
  } ctrl_t;

  // arith marks results that also produce C and H
  typedef struct packed {
    word_t value;
    logic  c;
    logic  h;
    logic  v;
    logic  arith;
  } alu_res_t;

endpackage

//--- hw/isa_pkg.sv
// instruction set definitions for the reduced AVR core
// instruction classes, ALU operation codes, pointer addressing modes
// and bit positions of the fields inside a 16-bit instruction word

package isa_pkg;

  // decoded instruction class
  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_RJMP,
    CLS_BRANCH,
    CLS_LD,
    CLS_ST,
    CLS_OUT,
    CLS_NOP
  } insn_class_e;

  // result selection inside the ALU
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_EOR,
    ALU_MOV,
    ALU_LDI,
    ALU_LOAD
  } alu_op_e;

  // X pointer addressing, encoded as in insn[1:0]
  typedef enum logic [1:0] {
    PTR_X     = 2'd0,
    PTR_X_INC = 2'd1,
    PTR_X_DEC = 2'd2
  } ptr_mode_e;

  localparam int IO_ADDR_W = 6;

  // field positions
  localparam int RD_LSB        = 4;
  localparam int RD_HI_BIT     = 8;
  localparam int RR_LSB        = 0;
  localparam int RR_HI_BIT     = 9;
  localparam int K_LO_LSB      = 0;
  localparam int K_HI_LSB      = 8;
  localparam int B_LSB         = 0;
  localparam int JMP_OFS_LSB   = 0;
  localparam int JMP_OFS_W     = 12;
  localparam int BR_OFS_LSB    = 3;
  localparam int BR_OFS_W      = 7;
  localparam int BR_CLR_BIT    = 10;
  localparam int ST_BIT        = 9;
  localparam int CARRY_SEL_BIT = 12;
  localparam int IO_A_HI_LSB   = 9;
  localparam int IO_A_LO_LSB   = 0;

endpackage
